// ==== csr_unit.f ====
src/csr_pkg.sv
src/perf_pkg.sv
src/csr_decoder.sv
src/csr_trap_regs.sv
src/csr_perf_counters.sv
src/csr_unit.sv
tb/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - src/csr_pkg.sv
  - src/perf_pkg.sv
  - src/csr_decoder.sv
  - src/csr_trap_regs.sv
  - src/csr_perf_counters.sv
  - src/csr_unit.sv
  - target: test
    files:
      - tb/csr_unit_tb.sv

// ==== tb/csr_unit_tb.sv ====
////////////////////
// testbench for the csr subsystem
// reference model, directed and random stimulus
// concurrent checks on rdata, irq enable and mepc
////////////////////

`timescale 1ns/1ps

module csr_unit_tb;

  localparam int CLK_PERIOD = 8;
  localparam int N_OPS      = 40;  // random csr operations
  localparam int N_COUNT    = 48;  // counting window, cycles
  localparam int N_SRC      = 7;
  // reset, identity, ops, traps, counting, saturation, then margin
  localparam int RUN_CYCLES = 10 + 2 * N_OPS + 7 * N_SRC + (N_COUNT + 13) + 40 + 100;
  localparam logic [11:0] PCCR_BASE = 12'h780;
  // save_if, save_id, save_branch, load_event
  localparam logic [3:0] SAVE_SRC [N_SRC] = '{4'b1000, 4'b0100, 4'b0010, 4'b0101,
                                              4'b1100, 4'b1010, 4'b1101};

  logic                clk;
  logic                rst_n;
  csr_pkg::csr_req_t   req;
  csr_pkg::trap_evt_t  trap;
  perf_pkg::perf_evt_t perf;
  logic [3:0]          core_id;
  logic [5:0]          cluster_id;
  logic [31:0]         rdata;
  logic                irq_enable;
  logic [31:0]         mepc;

  // reference model
  logic        m_irq, m_eirq;     // mstatus and mestatus enable
  logic [31:0] m_mepc, m_mcause, m_pcer, m_pcmr;
  logic        exp_valid;         // rdata compare armed
  logic [31:0] exp_rdata;
  int          errors, checks, err_mark;

  csr_unit csr_unit_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req),
    .trap_i       (trap),
    .perf_i       (perf),
    .core_id_i    (core_id),
    .cluster_id_i (cluster_id),
    .rdata_o      (rdata),
    .irq_enable_o (irq_enable),
    .mepc_o       (mepc)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("watchdog expired, tests did not finish in time");
    $display("Done: errors found");
    $finish;
  end

  ////////////////////
  // checks
  ////////////////////
  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    exp_valid |-> (rdata == exp_rdata))
    else begin
      errors++;
      $display("mismatch rdata_o at %h: got %h, expected %h",
               $sampled(req.addr.num), $sampled(rdata), $sampled(exp_rdata));
    end

  a_irq: assert property (@(posedge clk) disable iff (!rst_n) irq_enable == m_irq)
    else begin
      errors++;
      $display("mismatch irq_enable_o: got %h, expected %h", $sampled(irq_enable),
               $sampled(m_irq));
    end

  a_mepc: assert property (@(posedge clk) disable iff (!rst_n) mepc == m_mepc)
    else begin
      errors++;
      $display("mismatch mepc_o: got %h, expected %h", $sampled(mepc), $sampled(m_mepc));
    end

  ////////////////////
  // model
  ////////////////////
  function automatic logic [31:0] apply_op(input csr_pkg::csr_op_e op,
                                           input logic [31:0] old_v, input logic [31:0] wdata);
    case (op)
      csr_pkg::CSR_OP_SET:   return old_v | wdata;
      csr_pkg::CSR_OP_CLEAR: return old_v & ~wdata;
      default:               return wdata;
    endcase
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] addr);
    case (addr)
      csr_pkg::ADDR_MSTATUS:  return {29'b0, 2'b11, m_irq};
      csr_pkg::ADDR_MESTATUS: return {29'b0, 2'b11, m_eirq};
      csr_pkg::ADDR_MEPC:     return m_mepc;
      csr_pkg::ADDR_MCAUSE:   return m_mcause;
      csr_pkg::ADDR_PCER:     return m_pcer;
      csr_pkg::ADDR_PCMR:     return m_pcmr;
      csr_pkg::ADDR_MHARTID:  return {21'b0, cluster_id, 1'b0, core_id};
      default:                return '0;
    endcase
  endfunction

  function automatic void model_write(input logic [11:0] addr, input logic [31:0] v);
    case (addr)
      csr_pkg::ADDR_MSTATUS:  m_irq = v[0];
      csr_pkg::ADDR_MESTATUS: m_eirq = v[0];
      csr_pkg::ADDR_MEPC:     m_mepc = v;
      csr_pkg::ADDR_MCAUSE:   m_mcause = v & 32'h8000_001F; // irq flag and code
      csr_pkg::ADDR_PCER:     m_pcer = v & 32'h7FF;
      csr_pkg::ADDR_PCMR:     m_pcmr = v & 32'h3;
      default: ;                                          // counters tracked per test
    endcase
  endfunction

  ////////////////////
  // stimulus tasks
  ////////////////////
  task automatic step();
    @(posedge clk);
    #1; // drive after the edge
  endtask

  task automatic csr_op(input logic [11:0] addr, input csr_pkg::csr_op_e op,
                        input logic [31:0] wdata);
    logic [31:0] next_v;
    next_v = apply_op(op, model_read(addr), wdata); // same cycle read value
    req.access   = 1'b1;
    req.addr.num = addr;
    req.op       = op;
    req.wdata    = wdata;
    step();
    req = '0;
    model_write(addr, next_v);
  endtask

  task automatic csr_read(input logic [11:0] addr, input logic [31:0] expected);
    req.access   = 1'b1;
    req.addr.num = addr;
    exp_rdata    = expected;
    exp_valid    = 1'b1;
    checks++;
    step();
    exp_valid = 1'b0;
    req       = '0;
  endtask

  function automatic csr_pkg::trap_evt_t rand_trap(input logic [3:0] src);
    csr_pkg::trap_evt_t t;
    t = '0;
    {t.save_if, t.save_id, t.save_branch, t.load_event} = src;
    t.pc_if         = $urandom;
    t.pc_id         = $urandom;
    t.pc_ex         = $urandom;
    t.branch_target = $urandom;
    return t;
  endfunction

  task automatic trap_event(input csr_pkg::trap_evt_t t);
    trap = t;
    step();
    trap = '0;
    if (t.save_if || t.save_id || t.save_branch) begin
      m_eirq = m_irq;
      m_irq  = 1'b0;
      m_mepc = t.load_event  ? t.pc_ex :          // priority order
               t.save_branch ? t.branch_target :
               t.save_if     ? t.pc_if : t.pc_id;
    end
    if (t.save_cause) m_mcause = {t.cause[5], 26'b0, t.cause[4:0]};
    if (t.restore) m_irq = m_eirq;
  endtask

  // enable, n event cycles, disable; the disable cycle still counts
  task automatic run_counters(input logic [31:0] en, input int n, input bit loads,
                              output int n_cyc, output int n_ld);
    n_cyc = n + 1;
    n_ld  = 0;
    csr_op(csr_pkg::ADDR_PCER, csr_pkg::CSR_OP_WRITE, en);
    repeat (n) begin
      perf.mem_load  = loads ? 1'($urandom) : 1'b0;
      perf.mem_store = loads ? 1'($urandom) : 1'b0; // store slot stays disabled
      n_ld += perf.mem_load;
      step();
    end
    perf.mem_load  = 1'b0;
    perf.mem_store = 1'b0;
    csr_op(csr_pkg::ADDR_PCER, csr_pkg::CSR_OP_WRITE, 32'h0);
    repeat (3) step(); // quiet window, pipeline drained
  endtask

  task automatic end_test(input string name);
    $display("test %s finished, %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  ////////////////////
  // test sequence
  ////////////////////
  initial begin
    csr_pkg::csr_op_e   op;
    csr_pkg::trap_evt_t t;
    logic [11:0]        addr;
    int                 n_cyc, n_ld;
    void'($urandom(32'h351d));
    rst_n = 1'b0;
    req   = '0;
    trap  = '0;
    perf  = '0;
    core_id    = 4'($urandom);
    cluster_id = 6'($urandom);
    m_irq = 1'b0;
    m_eirq = 1'b0;
    m_mepc = '0;
    m_mcause = '0;
    m_pcer = '0;
    m_pcmr = 32'h3;
    exp_valid = 1'b0;
    exp_rdata = '0;
    errors = 0;
    checks = 0;
    err_mark = 0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;

    csr_read(csr_pkg::ADDR_MSTATUS, 32'h6);
    csr_read(csr_pkg::ADDR_PCMR, 32'h3);
    csr_read(csr_pkg::ADDR_MEPC, 32'h0);
    csr_read(csr_pkg::ADDR_MHARTID, {21'b0, cluster_id, 1'b0, core_id});
    csr_read(12'h123, 32'h0); // undecoded
    end_test("reset_identity");

    for (int i = 0; i < N_OPS; i++) begin
      case ($urandom_range(2))
        0:       addr = csr_pkg::ADDR_MEPC;
        1:       addr = csr_pkg::ADDR_MCAUSE;
        default: addr = csr_pkg::ADDR_PCER;
      endcase
      case ($urandom_range(2))
        0:       op = csr_pkg::CSR_OP_WRITE;
        1:       op = csr_pkg::CSR_OP_SET;
        default: op = csr_pkg::CSR_OP_CLEAR;
      endcase
      csr_op(addr, op, $urandom);
      csr_read(addr, model_read(addr));
    end
    end_test("operations");

    for (int i = 0; i < N_SRC; i++) begin
      csr_op(csr_pkg::ADDR_MSTATUS, csr_pkg::CSR_OP_SET, 32'h1);
      trap_event(rand_trap(SAVE_SRC[i]));
      csr_read(csr_pkg::ADDR_MESTATUS, model_read(csr_pkg::ADDR_MESTATUS));
      csr_read(csr_pkg::ADDR_MSTATUS, model_read(csr_pkg::ADDR_MSTATUS));
      t = '0;
      t.restore = 1'b1;
      trap_event(t);
      t = '0;
      t.save_cause = 1'b1;
      t.cause      = 6'($urandom);
      trap_event(t);
      csr_read(csr_pkg::ADDR_MCAUSE, model_read(csr_pkg::ADDR_MCAUSE));
    end
    end_test("trap_save_restore");

    csr_op(csr_pkg::ADDR_PCER, csr_pkg::CSR_OP_WRITE, 32'h0);
    repeat (3) step();
    csr_op(csr_pkg::ADDR_PCCR_ALL, csr_pkg::CSR_OP_WRITE, 32'h0);
    run_counters((32'h1 << perf_pkg::EV_CYCLE) | (32'h1 << perf_pkg::EV_LOAD), N_COUNT, 1'b1,
                 n_cyc, n_ld);
    csr_read(12'(PCCR_BASE + perf_pkg::EV_CYCLE), n_cyc);
    csr_read(12'(PCCR_BASE + perf_pkg::EV_LOAD), n_ld);
    csr_read(12'(PCCR_BASE + perf_pkg::EV_STORE), 32'h0); // not enabled
    end_test("counting");

    csr_op(csr_pkg::ADDR_PCCR_ALL, csr_pkg::CSR_OP_WRITE, 32'hFFFF_FFFD);
    for (int i = 0; i < perf_pkg::N_PERF; i++) begin
      csr_read(12'(PCCR_BASE + i), 32'hFFFF_FFFD);
    end
    run_counters(32'h1, 8, 1'b0, n_cyc, n_ld);
    csr_read(PCCR_BASE, 32'hFFFF_FFFF);     // held at all ones
    csr_op(csr_pkg::ADDR_PCMR, csr_pkg::CSR_OP_WRITE, 32'h1); // saturation off
    csr_read(csr_pkg::ADDR_PCMR, model_read(csr_pkg::ADDR_PCMR));
    csr_op(csr_pkg::ADDR_PCCR_ALL, csr_pkg::CSR_OP_WRITE, 32'hFFFF_FFFD);
    run_counters(32'h1, 2, 1'b0, n_cyc, n_ld);
    csr_read(PCCR_BASE, 32'(32'hFFFF_FFFD + n_cyc)); // three counts wrap to zero
    csr_op(csr_pkg::ADDR_PCMR, csr_pkg::CSR_OP_WRITE, 32'h3);
    end_test("saturation_alias");

    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== src/csr_unit.sv ====
////////////////////
// csr subsystem top
// decoder, trap registers, performance counters
////////////////////

`timescale 1ns/1ps

module csr_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_pkg::csr_req_t    req_i,
  input  csr_pkg::trap_evt_t   trap_i,
  input  perf_pkg::perf_evt_t  perf_i,
  input  logic [3:0]           core_id_i,
  input  logic [5:0]           cluster_id_i,
  output logic [31:0]          rdata_o,
  output logic                 irq_enable_o,
  output logic [31:0]          mepc_o
);

  csr_pkg::csr_wr_t wr;          // post-op data and enables
  logic [31:0]      trap_rdata;
  logic [31:0]      perf_rdata;
  logic [4:0]       pccr_index;

  csr_decoder csr_decoder_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .trap_rdata_i (trap_rdata),
    .perf_rdata_i (perf_rdata),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .rdata_o      (rdata_o),
    .wr_o         (wr),
    .pccr_index_o (pccr_index)
  );

  // trap bank, reads by flat address
  csr_trap_regs csr_trap_regs_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .addr_i       (req_i.addr),
    .wr_i         (wr),
    .trap_i       (trap_i),
    .rdata_o      (trap_rdata),
    .irq_enable_o (irq_enable_o),
    .mepc_o       (mepc_o)
  );

  csr_perf_counters csr_perf_counters_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .perf_i       (perf_i),
    .wr_i         (wr),
    .addr_i       (req_i.addr),
    .pccr_index_i (pccr_index),
    .rdata_o      (perf_rdata)
  );

endmodule

// ==== src/csr_perf_counters.sv ====
////////////////////
// performance counters
// event gating, pcer, pcmr, counter array with saturation
////////////////////

`timescale 1ns/1ps

module csr_perf_counters (
  input  logic                 clk,
  input  logic                 rst_n,
  input  perf_pkg::perf_evt_t  perf_i,
  input  csr_pkg::csr_wr_t     wr_i,
  input  csr_pkg::csr_addr_u   addr_i,
  input  logic [4:0]           pccr_index_i,
  output logic [31:0]          rdata_o
);

  logic                                 id_valid_q; // qualifies stall and branch events
  logic [perf_pkg::N_PERF-1:0]          ev;
  logic [perf_pkg::N_PERF-1:0]          inc, inc_q;
  logic [perf_pkg::N_PERF-1:0]          pcer_q;     // per counter enable
  logic [1:0]                           pcmr_q;     // bit 1 saturate, bit 0 global enable
  logic [perf_pkg::N_PERF-1:0][31:0]    pccr_q, pccr_n;

  ////////////////////
  // event sources
  ////////////////////
  assign ev[perf_pkg::EV_CYCLE]        = 1'b1;
  assign ev[perf_pkg::EV_INSTR]        = perf_i.id_valid & perf_i.is_decoding;
  assign ev[perf_pkg::EV_LD_STALL]     = perf_i.ld_stall & id_valid_q;
  assign ev[perf_pkg::EV_JR_STALL]     = perf_i.jr_stall & id_valid_q;
  assign ev[perf_pkg::EV_IMISS]        = perf_i.imiss & ~perf_i.pc_set; // no jump refetch
  assign ev[perf_pkg::EV_LOAD]         = perf_i.mem_load;
  assign ev[perf_pkg::EV_STORE]        = perf_i.mem_store;
  assign ev[perf_pkg::EV_JUMP]         = perf_i.jump & id_valid_q;
  assign ev[perf_pkg::EV_BRANCH]       = perf_i.branch & id_valid_q;
  assign ev[perf_pkg::EV_BRANCH_TAKEN] = perf_i.branch & perf_i.branch_taken & id_valid_q;
  assign ev[perf_pkg::EV_COMPRESSED]   = perf_i.id_valid & perf_i.is_decoding
                                         & perf_i.is_compressed;

  assign inc = ev & pcer_q & {perf_pkg::N_PERF{pcmr_q[0]}};

  // increment from registered event, csr write has priority
  always_comb begin
    for (int i = 0; i < perf_pkg::N_PERF; i++) begin
      pccr_n[i] = pccr_q[i];
      if (inc_q[i] && ((pccr_q[i] != '1) || !pcmr_q[1])) begin
        pccr_n[i] = pccr_q[i] + 32'd1;
      end
      if (wr_i.we_pccr && (wr_i.pccr_all || (pccr_index_i == 5'(i)))) begin
        pccr_n[i] = wr_i.wdata;
      end
    end
  end

  // readback
  always_comb begin
    rdata_o = '0;
    if (addr_i.num == csr_pkg::ADDR_PCER) begin
      rdata_o[perf_pkg::N_PERF-1:0] = pcer_q;
    end else if (addr_i.num == csr_pkg::ADDR_PCMR) begin
      rdata_o[1:0] = pcmr_q;
    end else if ((addr_i.pccr.prefix == csr_pkg::PCCR_PREFIX) &&
                 (addr_i.pccr.index < perf_pkg::N_PERF)) begin
      rdata_o = pccr_q[addr_i.pccr.index]; // unused slots read zero
    end
  end

  ////////////////////
  // registers
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      pcer_q     <= '0;
      pcmr_q     <= 2'b11; // counting and saturating out of reset
      pccr_q     <= '0;
    end else begin
      id_valid_q <= perf_i.id_valid;
      inc_q      <= inc;
      pccr_q     <= pccr_n;
      if (wr_i.we_pcer) pcer_q <= wr_i.wdata[perf_pkg::N_PERF-1:0];
      if (wr_i.we_pcmr) pcmr_q <= wr_i.wdata[1:0];
    end
  end

  // single counter writes stay inside the implemented slots
  a_pccr_index: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_i.we_pccr && !wr_i.pccr_all) |-> (pccr_index_i < perf_pkg::N_PERF));

endmodule

// ==== src/csr_trap_regs.sv ====
////////////////////
// trap state registers
// mstatus, mestatus, mepc, mcause
// trap save, cause and restore over csr writes
////////////////////

`timescale 1ns/1ps

module csr_trap_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  csr_pkg::csr_addr_u addr_i,
  input  csr_pkg::csr_wr_t   wr_i,
  input  csr_pkg::trap_evt_t trap_i,
  output logic [31:0]        rdata_o,
  output logic               irq_enable_o,
  output logic [31:0]        mepc_o
);

  logic        mstatus_q, mstatus_n;   // interrupt enable
  logic        mestatus_q, mestatus_n; // saved enable
  logic [31:0] mepc_q, mepc_n;
  logic [5:0]  mcause_q, mcause_n;     // bit 5 is the interrupt flag
  logic        save;

  assign save = trap_i.save_if || trap_i.save_id || trap_i.save_branch;

  // readback, m-mode bits 2:1 always set
  always_comb begin
    case (addr_i.num)
      csr_pkg::ADDR_MSTATUS:  rdata_o = {29'b0, 2'b11, mstatus_q};
      csr_pkg::ADDR_MEPC:     rdata_o = mepc_q;
      csr_pkg::ADDR_MCAUSE:   rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      csr_pkg::ADDR_MESTATUS: rdata_o = {29'b0, 2'b11, mestatus_q};
      default:                rdata_o = '0;
    endcase
  end

  ////////////////////
  // next state
  ////////////////////
  always_comb begin
    mstatus_n  = wr_i.we_mstatus  ? wr_i.wdata[0] : mstatus_q;
    mestatus_n = wr_i.we_mestatus ? wr_i.wdata[0] : mestatus_q;
    mepc_n     = wr_i.we_mepc     ? wr_i.wdata    : mepc_q;
    mcause_n   = wr_i.we_mcause   ? {wr_i.wdata[31], wr_i.wdata[4:0]} : mcause_q;

    // exception controller wins over csr writes
    if (save) begin
      mestatus_n = mstatus_q;
      mstatus_n  = 1'b0;           // irqs off in handler
      if (trap_i.load_event)       mepc_n = trap_i.pc_ex;
      else if (trap_i.save_branch) mepc_n = trap_i.branch_target;
      else if (trap_i.save_if)     mepc_n = trap_i.pc_if;
      else                         mepc_n = trap_i.pc_id;
    end
    if (trap_i.save_cause) mcause_n  = trap_i.cause;
    if (trap_i.restore)    mstatus_n = mestatus_q; // mret
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q  <= 1'b0;
      mestatus_q <= 1'b0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      mstatus_q  <= mstatus_n;
      mestatus_q <= mestatus_n;
      mepc_q     <= mepc_n;
      mcause_q   <= mcause_n;
    end
  end

  assign irq_enable_o = mstatus_q;
  assign mepc_o       = mepc_q;

  // load fault in ex and a taken branch cannot trap together
  a_branch_vs_load: assert property (@(posedge clk) disable iff (!rst_n)
    !(trap_i.save_branch && trap_i.load_event));

endmodule

// ==== src/csr_decoder.sv ====
////////////////////
// csr access decoder
// read select, set/clear combine, target write enables
////////////////////

`timescale 1ns/1ps

module csr_decoder (
  input  logic              clk,
  input  logic              rst_n,
  input  csr_pkg::csr_req_t req_i,
  input  logic [31:0]       trap_rdata_i,
  input  logic [31:0]       perf_rdata_i,
  input  logic [3:0]        core_id_i,
  input  logic [5:0]        cluster_id_i,
  output logic [31:0]       rdata_o,
  output csr_pkg::csr_wr_t  wr_o,
  output logic [4:0]        pccr_index_o
);

  csr_pkg::csr_addr_u addr;
  logic               is_trap;      // mstatus, mepc, mcause, mestatus
  logic               is_perf;      // pcer, pcmr, counter window
  logic [31:0]        local_rdata;  // identity registers
  logic               we_any;

  assign addr = req_i.addr;

  ////////////////////
  // read side
  ////////////////////
  always_comb begin
    is_trap     = 1'b0;
    is_perf     = 1'b0;
    local_rdata = '0; // undecoded reads zero
    case (addr.num)
      csr_pkg::ADDR_MSTATUS, csr_pkg::ADDR_MEPC,
      csr_pkg::ADDR_MCAUSE, csr_pkg::ADDR_MESTATUS: is_trap = 1'b1;
      csr_pkg::ADDR_MCPUID:  local_rdata = csr_pkg::MCPUID_VAL;
      csr_pkg::ADDR_MIMPID:  local_rdata = csr_pkg::MIMPID_VAL;
      // cluster id above a spare bit and core id
      csr_pkg::ADDR_MHARTID: local_rdata = {21'b0, cluster_id_i, 1'b0, core_id_i};
      csr_pkg::ADDR_PCER, csr_pkg::ADDR_PCMR: is_perf = 1'b1;
      default: ;
    endcase
    if (addr.pccr.prefix == csr_pkg::PCCR_PREFIX) begin
      is_perf = 1'b1; // 0x780..0x79F, alias included
    end
  end

  assign rdata_o = is_trap ? trap_rdata_i :
                   is_perf ? perf_rdata_i : local_rdata;

  ////////////////////
  // write side
  ////////////////////
  assign we_any = req_i.access && (req_i.op != csr_pkg::CSR_OP_NONE);

  always_comb begin
    wr_o = '0;
    case (req_i.op)
      csr_pkg::CSR_OP_SET:   wr_o.wdata = req_i.wdata | rdata_o;
      csr_pkg::CSR_OP_CLEAR: wr_o.wdata = ~req_i.wdata & rdata_o;
      default:               wr_o.wdata = req_i.wdata; // write, none
    endcase
    wr_o.we_mstatus  = we_any && (addr.num == csr_pkg::ADDR_MSTATUS);
    wr_o.we_mepc     = we_any && (addr.num == csr_pkg::ADDR_MEPC);
    wr_o.we_mcause   = we_any && (addr.num == csr_pkg::ADDR_MCAUSE);
    wr_o.we_mestatus = we_any && (addr.num == csr_pkg::ADDR_MESTATUS);
    wr_o.we_pcer     = we_any && (addr.num == csr_pkg::ADDR_PCER);
    wr_o.we_pcmr     = we_any && (addr.num == csr_pkg::ADDR_PCMR);
    wr_o.we_pccr     = we_any && (addr.pccr.prefix == csr_pkg::PCCR_PREFIX);
    wr_o.pccr_all    = we_any && (addr.num == csr_pkg::ADDR_PCCR_ALL);
  end

  assign pccr_index_o = addr.pccr.index;

  // at most one trap register written per cycle
  a_trap_we_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({wr_o.we_mstatus, wr_o.we_mepc, wr_o.we_mcause, wr_o.we_mestatus}));

  // idle port never writes anything downstream
  a_no_we_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !req_i.access |-> !(wr_o.we_mstatus || wr_o.we_mepc || wr_o.we_mcause ||
                        wr_o.we_mestatus || wr_o.we_pcer || wr_o.we_pcmr ||
                        wr_o.we_pccr));

endmodule

// ==== src/perf_pkg.sv ====
////////////////////
// performance counter definitions
// counter count, event indices, core status struct
////////////////////

package perf_pkg;

  localparam int unsigned N_PERF = 11;

  // counter slot per event
  localparam int unsigned EV_CYCLE        = 0;
  localparam int unsigned EV_INSTR        = 1;
  localparam int unsigned EV_LD_STALL     = 2;  // load use hazard
  localparam int unsigned EV_JR_STALL     = 3;  // jump register hazard
  localparam int unsigned EV_IMISS        = 4;
  localparam int unsigned EV_LOAD         = 5;
  localparam int unsigned EV_STORE        = 6;
  localparam int unsigned EV_JUMP         = 7;
  localparam int unsigned EV_BRANCH       = 8;
  localparam int unsigned EV_BRANCH_TAKEN = 9;
  localparam int unsigned EV_COMPRESSED   = 10;

  // raw status bits from the core pipeline
  typedef struct packed {
    logic id_valid;      // id stage done
    logic is_compressed;
    logic is_decoding;   // controller in decode
    logic imiss;
    logic pc_set;
    logic jump;
    logic branch;
    logic branch_taken;
    logic ld_stall;
    logic jr_stall;
    logic mem_load;
    logic mem_store;
  } perf_evt_t;

endpackage

// ==== src/csr_pkg.sv ====
////////////////////
// csr access port definitions
// addresses, operation codes, identity values
// access, write command and trap event structs
////////////////////

package csr_pkg;

  // csr operation codes
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  ////////////////////
  // csr numbers
  ////////////////////
  localparam logic [11:0] ADDR_MSTATUS  = 12'h300;
  localparam logic [11:0] ADDR_MEPC     = 12'h341;
  localparam logic [11:0] ADDR_MCAUSE   = 12'h342;
  localparam logic [11:0] ADDR_MESTATUS = 12'h7C0;
  localparam logic [11:0] ADDR_MCPUID   = 12'hF00;
  localparam logic [11:0] ADDR_MIMPID   = 12'hF01;
  localparam logic [11:0] ADDR_MHARTID  = 12'hF10;
  localparam logic [11:0] ADDR_PCER     = 12'h7A0;
  localparam logic [11:0] ADDR_PCMR     = 12'h7A1;
  localparam logic [11:0] ADDR_PCCR_ALL = 12'h79F; // writes every counter
  localparam logic [6:0]  PCCR_PREFIX   = 7'b0111100; // window 0x780..0x79F

  localparam logic [31:0] MCPUID_VAL = 32'h0080_1100; // rv32im plus custom
  localparam logic [31:0] MIMPID_VAL = 32'h0000_8000;

  // counter view of a csr number
  typedef struct packed {
    logic [6:0] prefix;
    logic [4:0] index;
  } pccr_addr_t;

  // one address word, flat number or counter window view
  typedef union packed {
    logic [11:0] num;
    pccr_addr_t  pccr;
  } csr_addr_u;

  typedef struct packed {
    logic        access;
    csr_addr_u   addr;
    csr_op_e     op;
    logic [31:0] wdata;
  } csr_req_t;

  // decoder write command, wdata already combined per op
  typedef struct packed {
    logic [31:0] wdata;
    logic        we_mstatus;
    logic        we_mepc;
    logic        we_mcause;
    logic        we_mestatus;
    logic        we_pcer;
    logic        we_pcmr;
    logic        we_pccr;
    logic        pccr_all;
  } csr_wr_t;

  // exception controller inputs, level sampled
  typedef struct packed {
    logic        save_if;
    logic        save_id;
    logic        save_branch;
    logic        load_event;
    logic        restore;
    logic        save_cause;
    logic [5:0]  cause;
    logic [31:0] pc_if;
    logic [31:0] pc_id;
    logic [31:0] pc_ex;
    logic [31:0] branch_target;
  } trap_evt_t;

endpackage
